// File: hand_select.sv
`default_nettype none

module hand_select import rps_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  t_hand_keys i_keys,
	output t_gesture   o_left,
	output t_gesture   o_right
);

	// lowest pressed key wins, nothing pressed keeps the old choice
	function automatic t_gesture pick(input logic [2:0] keys, input t_gesture held);
		t_gesture g;
		if (keys[0])
			g = G_ROCK;
		else if (keys[1])
			g = G_SCISSORS;
		else if (keys[2])
			g = G_PAPER;
		else
			g = held;
		return g;
	endfunction

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_left  <= G_NONE;
			o_right <= G_NONE;
		end else begin
			o_left  <= pick(i_keys.left_keys, o_left);
			o_right <= pick(i_keys.right_keys, o_right);
		end
	end

endmodule

`default_nettype wire

// File: key_debouncer.sv
`default_nettype none

module key_debouncer #(
	parameter type t_payload = logic,
	parameter int  p_sample_div = 4
) (
	input  wire      i_clk,
	input  wire      i_rst,
	input  t_payload i_keys,
	output t_payload o_keys
);

	localparam int W  = $bits(t_payload);
	localparam int CW = (p_sample_div > 1) ? $clog2(p_sample_div) : 1;

	logic [CW-1:0] tick_cnt;
	logic          tick;
	logic [W-1:0]  samp_1;
	logic [W-1:0]  samp_2;

	assign tick = (tick_cnt == CW'(p_sample_div - 1));

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			tick_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// per bit: pass the older sample only while both samples agree
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			samp_1 <= '0;
			samp_2 <= '0;
			o_keys <= t_payload'('0);
		end else if (tick) begin
			samp_1 <= W'(i_keys);
			samp_2 <= samp_1;
			o_keys <= t_payload'(~(samp_1 ^ samp_2) & samp_2);
		end
	end

endmodule

`default_nettype wire

// File: referee.sv
`default_nettype none

module referee import rps_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  t_ctrl_keys i_ctrl,
	input  t_gesture   i_left,
	input  t_gesture   i_right,
	output t_score     o_score_left,
	output t_score     o_score_right,
	output logic       o_winner_left,
	output logic       o_winner_right
);

	logic start_d;
	logic start_rise;
	logic match_over;
	logic round_ok;

	function automatic logic beats(input t_gesture a, input t_gesture b);
		return (a == G_ROCK     && b == G_SCISSORS) ||
		       (a == G_SCISSORS && b == G_PAPER)    ||
		       (a == G_PAPER    && b == G_ROCK);
	endfunction

	assign start_rise = i_ctrl.start & ~start_d;
	assign match_over = o_winner_left | o_winner_right;
	assign round_ok   = (i_left != G_NONE) && (i_right != G_NONE) && !match_over;

	assign o_winner_left  = (o_score_left >= WIN_SCORE);
	assign o_winner_right = (o_score_right >= WIN_SCORE);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			start_d       <= 1'b0;
			o_score_left  <= '0;
			o_score_right <= '0;
		end else begin
			start_d <= i_ctrl.start;
			if (i_ctrl.clear) begin // clear wins over start
				o_score_left  <= '0;
				o_score_right <= '0;
			end else if (start_rise && round_ok) begin
				if (beats(i_left, i_right))
					o_score_left <= o_score_left + 1'b1;
				else if (beats(i_right, i_left))
					o_score_right <= o_score_right + 1'b1;
				// tie scores nothing
			end
		end
	end

endmodule

`default_nettype wire

// File: rps_assertions.sv
`default_nettype none

module rps_assertions import rps_pkg::*; (
	input wire    clk,
	input wire    rst,
	input t_score i_score_left,
	input t_score i_score_right,
	input wire    i_winner_left,
	input wire    i_winner_right
);

	a_left_max: assert property (@(posedge clk) disable iff (!rst)
		i_score_left <= WIN_SCORE)
		else $error("left score above match limit");

	a_right_max: assert property (@(posedge clk) disable iff (!rst)
		i_score_right <= WIN_SCORE)
		else $error("right score above match limit");

	a_one_winner: assert property (@(posedge clk) disable iff (!rst)
		!(i_winner_left && i_winner_right))
		else $error("both winner lines high");

	// hold, step by one, or cleared
	a_left_step: assert property (@(posedge clk) disable iff (!rst)
		(i_score_left == $past(i_score_left)) ||
		(i_score_left == t_score'($past(i_score_left) + 3'd1)) ||
		(i_score_left == 3'd0))
		else $error("left score jumped");

	a_right_step: assert property (@(posedge clk) disable iff (!rst)
		(i_score_right == $past(i_score_right)) ||
		(i_score_right == t_score'($past(i_score_right) + 3'd1)) ||
		(i_score_right == 3'd0))
		else $error("right score jumped");

endmodule

bind referee rps_assertions u_rps_assertions (
	.clk            (clk),
	.rst            (rst),
	.i_score_left   (o_score_left),
	.i_score_right  (o_score_right),
	.i_winner_left  (o_winner_left),
	.i_winner_right (o_winner_right)
);

`default_nettype wire

// File: rps_game_top.sv
`default_nettype none

module rps_game_top import rps_pkg::*; #(
	parameter int p_sample_div = SAMPLE_DIV_DEF,
	parameter int p_scan_div   = SCAN_DIV_DEF
) (
	input  wire              clk,
	input  wire              rst,
	input  wire  [2:0]       i_left_keys,
	input  wire  [2:0]       i_right_keys,
	input  wire              i_start,
	input  wire              i_clear,
	output logic [SEG_W-1:0] o_dig,
	output logic [SEG_W-1:0] o_seg,
	output logic             o_winner_left,
	output logic             o_winner_right
);

	t_hand_keys hand_raw;
	t_hand_keys hand_stable;
	t_ctrl_keys ctrl_raw;
	t_ctrl_keys ctrl_stable;
	t_gesture   gest_left;
	t_gesture   gest_right;
	t_score     score_left;
	t_score     score_right;

	assign hand_raw.left_keys  = i_left_keys;
	assign hand_raw.right_keys = i_right_keys;
	assign ctrl_raw.start      = i_start;
	assign ctrl_raw.clear      = i_clear;

	key_debouncer #(
		.t_payload    (t_hand_keys),
		.p_sample_div (p_sample_div)
	) kd_hand (
		.i_clk  (clk),
		.i_rst  (rst),
		.i_keys (hand_raw),
		.o_keys (hand_stable)
	);

	key_debouncer #(
		.t_payload    (t_ctrl_keys),
		.p_sample_div (p_sample_div)
	) kd_ctrl (
		.i_clk  (clk),
		.i_rst  (rst),
		.i_keys (ctrl_raw),
		.o_keys (ctrl_stable)
	);

	hand_select u_hand_select (
		.clk     (clk),
		.rst     (rst),
		.i_keys  (hand_stable),
		.o_left  (gest_left),
		.o_right (gest_right)
	);

	referee u_referee (
		.clk            (clk),
		.rst            (rst),
		.i_ctrl         (ctrl_stable),
		.i_left         (gest_left),
		.i_right        (gest_right),
		.o_score_left   (score_left),
		.o_score_right  (score_right),
		.o_winner_left  (o_winner_left),
		.o_winner_right (o_winner_right)
	);

	score_display #(
		.p_scan_div (p_scan_div)
	) u_score_display (
		.clk           (clk),
		.rst           (rst),
		.i_score_left  (score_left),
		.i_score_right (score_right),
		.o_dig         (o_dig),
		.o_seg         (o_seg)
	);

endmodule

`default_nettype wire

// File: rps_pkg.sv
`default_nettype none

package rps_pkg;

	typedef logic [2:0] t_gesture; // one-hot, bit 0 rock
	typedef logic [2:0] t_score;

	typedef struct packed {
		logic [2:0] left_keys; // rock, scissors, paper from bit 0
		logic [2:0] right_keys;
	} t_hand_keys;

	typedef struct packed {
		logic start;
		logic clear;
	} t_ctrl_keys;

	localparam t_gesture G_NONE     = 3'b000;
	localparam t_gesture G_ROCK     = 3'b001;
	localparam t_gesture G_SCISSORS = 3'b010;
	localparam t_gesture G_PAPER    = 3'b100;

	localparam t_score WIN_SCORE = 3'd3; // match ends here

	localparam int SEG_W = 8;

	// gfedcba, active high, dp always off
	localparam logic [0:4][SEG_W-1:0] SEG_TABLE = {
		8'h3F, // 0
		8'h06, // 1
		8'h5B, // 2
		8'h4F, // 3
		8'h00  // blank
	};
	localparam int SEG_BLANK = 4; // index of blank pattern

	localparam int DIG_RIGHT = 0;
	localparam int DIG_LEFT  = 7;

	localparam int SAMPLE_DIV_DEF = 250000; // ~5 ms at 50 MHz
	localparam int SCAN_DIV_DEF   = 25000;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_rps_game

out=$(./obj_dir/Vtb_rps_game 2>&1) || true
echo "$out"

if grep -qx "Done: no errors" <<< "$out"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: score_display.sv
`default_nettype none

module score_display import rps_pkg::*; #(
	parameter int p_scan_div = 4
) (
	input  wire              clk,
	input  wire              rst,
	input  t_score           i_score_left,
	input  t_score           i_score_right,
	output logic [SEG_W-1:0] o_dig,
	output logic [SEG_W-1:0] o_seg
);

	localparam int CW = (p_scan_div > 1) ? $clog2(p_scan_div) : 1;

	logic [CW-1:0]    scan_cnt;
	logic             scan_tick;
	logic [2:0]       pos; // digit 0..7
	logic [SEG_W-1:0] dig_sel;
	logic [SEG_W-1:0] seg_pat;

	function automatic logic [SEG_W-1:0] seg_of(input t_score s);
		logic [SEG_W-1:0] p;
		if (s < t_score'(SEG_BLANK))
			p = SEG_TABLE[s];
		else
			p = SEG_TABLE[SEG_BLANK]; // out of range shows nothing
		return p;
	endfunction

	assign scan_tick = (scan_cnt == CW'(p_scan_div - 1));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			scan_cnt <= '0;
			pos      <= '0;
		end else if (scan_tick) begin
			scan_cnt <= '0;
			pos      <= pos + 1'b1; // wraps 7 -> 0
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	always_comb begin
		dig_sel = '0;
		seg_pat = SEG_TABLE[SEG_BLANK];
		if (pos == 3'(DIG_RIGHT)) begin
			dig_sel = SEG_W'(1) << DIG_RIGHT;
			seg_pat = seg_of(i_score_right);
		end else if (pos == 3'(DIG_LEFT)) begin
			dig_sel = SEG_W'(1) << DIG_LEFT;
			seg_pat = seg_of(i_score_left);
		end
	end

	// board is active low on both buses
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_dig <= '1;
			o_seg <= '1;
		end else begin
			o_dig <= ~dig_sel;
			o_seg <= ~seg_pat;
		end
	end

endmodule

`default_nettype wire

// File: tb_rps_game.sv
`default_nettype none

module tb_rps_game import rps_pkg::*; ();

	localparam int SAMPLE_DIV = 4;
	localparam int SCAN_DIV   = 2;
	localparam int HOLD_CYC   = 20 * SAMPLE_DIV; // press and start hold, 20 sample ticks

	localparam logic [1:0] K_ROCK  = 2'd0;
	localparam logic [1:0] K_SCIS  = 2'd1;
	localparam logic [1:0] K_PAPER = 2'd2;
	localparam logic [1:0] K_NONE  = 2'd3; // no key this row

	typedef struct packed {
		logic [1:0] left_idx;
		logic [1:0] right_idx;
		logic       clear;
		t_score     exp_left;
		t_score     exp_right;
		logic [1:0] exp_win; // {left, right}
	} t_row;

	logic             clk;
	logic             rst;
	logic [2:0]       left_keys;
	logic [2:0]       right_keys;
	logic             start;
	logic             clear;
	logic [SEG_W-1:0] dig;
	logic [SEG_W-1:0] seg;
	logic             winner_left;
	logic             winner_right;

	t_row table_q[$];
	int   cycle_cnt = 0;
	int   limit_cyc = 0;

	rps_game_top #(
		.p_sample_div (SAMPLE_DIV),
		.p_scan_div   (SCAN_DIV)
	) dut0 (
		.clk            (clk),
		.rst            (rst),
		.i_left_keys    (left_keys),
		.i_right_keys   (right_keys),
		.i_start        (start),
		.i_clear        (clear),
		.o_dig          (dig),
		.o_seg          (seg),
		.o_winner_left  (winner_left),
		.o_winner_right (winner_right)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (limit_cyc > 0 && cycle_cnt >= limit_cyc)
			abort_run("timeout: display never selected the score digit");
	end

	task automatic check_score(input string name, input t_score got, input t_score exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic verify_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic expect_pattern(input string name, input logic [SEG_W-1:0] got,
			input logic [SEG_W-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// rock, scissors, paper on bits 0..2
	function automatic logic [2:0] key_bits(input logic [1:0] idx);
		logic [2:0] b;
		if (idx == K_NONE)
			b = 3'b000;
		else
			b = 3'b001 << idx;
		return b;
	endfunction

	task automatic add_row(input logic [1:0] l, input logic [1:0] r, input logic c,
			input t_score el, input t_score er, input logic [1:0] w);
		t_row row;
		row.left_idx  = l;
		row.right_idx = r;
		row.clear     = c;
		row.exp_left  = el;
		row.exp_right = er;
		row.exp_win   = w;
		table_q.push_back(row);
	endtask

	task automatic load_table();
		add_row(K_NONE,  K_NONE,  1'b0, 3'd0, 3'd0, 2'b00); // start with no gesture
		add_row(K_ROCK,  K_SCIS,  1'b0, 3'd1, 3'd0, 2'b00);
		add_row(K_SCIS,  K_ROCK,  1'b0, 3'd1, 3'd1, 2'b00);
		add_row(K_SCIS,  K_PAPER, 1'b0, 3'd2, 3'd1, 2'b00);
		add_row(K_PAPER, K_SCIS,  1'b0, 3'd2, 3'd2, 2'b00);
		add_row(K_ROCK,  K_SCIS,  1'b1, 3'd0, 3'd0, 2'b00); // start under clear
		add_row(K_PAPER, K_ROCK,  1'b0, 3'd1, 3'd0, 2'b00);
		add_row(K_ROCK,  K_PAPER, 1'b0, 3'd1, 3'd1, 2'b00);
		add_row(K_ROCK,  K_ROCK,  1'b0, 3'd1, 3'd1, 2'b00); // ties
		add_row(K_SCIS,  K_SCIS,  1'b0, 3'd1, 3'd1, 2'b00);
		add_row(K_PAPER, K_PAPER, 1'b0, 3'd1, 3'd1, 2'b00);
		add_row(K_ROCK,  K_SCIS,  1'b0, 3'd2, 3'd1, 2'b00);
		add_row(K_ROCK,  K_SCIS,  1'b0, 3'd3, 3'd1, 2'b10); // left takes the match
		add_row(K_ROCK,  K_PAPER, 1'b0, 3'd3, 3'd1, 2'b10);
		add_row(K_ROCK,  K_SCIS,  1'b0, 3'd3, 3'd1, 2'b10);
		add_row(K_ROCK,  K_ROCK,  1'b1, 3'd0, 3'd0, 2'b00);
		add_row(K_SCIS,  K_ROCK,  1'b0, 3'd0, 3'd1, 2'b00);
		add_row(K_SCIS,  K_ROCK,  1'b0, 3'd0, 3'd2, 2'b00);
		add_row(K_SCIS,  K_ROCK,  1'b0, 3'd0, 3'd3, 2'b01);
		add_row(K_PAPER, K_ROCK,  1'b0, 3'd0, 3'd3, 2'b01); // frozen after match end
	endtask

	// leaves us on a falling edge with the wanted digit selected
	task automatic wait_digit(input int pos);
		logic [SEG_W-1:0] want;
		logic [SEG_W-1:0] other;
		want  = ~(SEG_W'(1) << pos);
		other = ~(SEG_W'(1) << ((pos == DIG_RIGHT) ? DIG_LEFT : DIG_RIGHT));
		do begin
			@(negedge clk);
			if (dig !== want && dig !== other) begin // unused positions stay dark
				expect_pattern("o_dig (idle digit)", dig, '1);
				expect_pattern("o_seg (idle digit)", seg, '1);
			end
		end while (dig !== want);
	endtask

	task automatic show_and_compare(input t_score el, input t_score er, input logic [1:0] w);
		wait_digit(DIG_RIGHT);
		expect_pattern("o_seg (right digit)", seg, ~SEG_TABLE[er]);
		wait_digit(DIG_LEFT);
		expect_pattern("o_seg (left digit)", seg, ~SEG_TABLE[el]);
		check_score("score_left", dut0.score_left, el);
		check_score("score_right", dut0.score_right, er);
		verify_bit("o_winner_left", winner_left, w[1]);
		verify_bit("o_winner_right", winner_right, w[0]);
	endtask

	task automatic apply_row(input t_row r);
		@(posedge clk);
		left_keys  <= key_bits(r.left_idx);
		right_keys <= key_bits(r.right_idx);
		clear      <= r.clear;
		repeat (HOLD_CYC) @(posedge clk);
		left_keys  <= 3'b000; // gesture stays held
		right_keys <= 3'b000;
		start      <= 1'b1;
		repeat (HOLD_CYC) @(posedge clk);
		start <= 1'b0;
		repeat (HOLD_CYC) @(posedge clk);
		show_and_compare(r.exp_left, r.exp_right, r.exp_win);
	endtask

	initial begin
		rst        = 1'b0;
		left_keys  = 3'b000;
		right_keys = 3'b000;
		start      = 1'b0;
		clear      = 1'b0;
		load_table();
		limit_cyc = table_q.size() * 400 + 200;
		repeat (5) @(posedge clk);
		rst <= 1'b1;

		show_and_compare(3'd0, 3'd0, 2'b00); // state right after reset

		foreach (table_q[i])
			apply_row(table_q[i]);

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
rps_pkg.sv
key_debouncer.sv
hand_select.sv
referee.sv
score_display.sv
rps_game_top.sv
rps_assertions.sv
tb_rps_game.sv
